// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert

FILELIST := build.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
HDRS     := $(wildcard *.svh)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --binary -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+.
lsu_pkg.sv
mem_pkg.sv
store_lane_unit.sv
data_ram.sv
load_align.sv
lsu_top.sv
tb_lsu.sv

// ==== data_ram.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module data_ram (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ena,
  input  logic                wen,
  input  lsu_pkg::xlen_t      addr,
  input  mem_pkg::lane_mask_t byte_mask,
  input  lsu_pkg::xlen_t      store_dword,
  input  logic                misaligned,
  output lsu_pkg::xlen_t      read_dword,
  output logic                access_fault
);

  import lsu_pkg::*;
  import mem_pkg::*;

  localparam int AW    = `LSU_RAM_WORDS_LOG2;
  localparam int DEPTH = 1 << AW;
  localparam int LANES = `LSU_XLEN / 8;

  dword_u        mem [DEPTH];
  dword_u        wr_data;
  xlen_t         rel;
  logic [AW-1:0] idx;
  logic          in_window;
  logic          hit;
  logic          we;

  // below-base addresses wrap to a large offset and fall out too
  assign rel       = addr - `LSU_RAM_BASE;
  assign in_window = (rel[63:AW+3] == '0);
  assign idx       = rel[AW+2:3];

  assign hit          = ena & in_window;
  assign access_fault = ena & ~in_window;

  assign read_dword = hit ? mem[idx].d : '0;

  // faulting or reset-time accesses leave the ram alone
  assign we      = hit & wen & ~misaligned & rst_n;
  assign wr_data = store_dword;

  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < LANES; i++) begin
        if (byte_mask[i]) begin
          mem[idx].b[i] <= wr_data.b[i];
        end
      end
    end
  end

  // every write the array accepts touches at least one lane
  assert property (@(posedge clk) disable iff (!rst_n) we |-> (byte_mask != '0))
    else $error("data_ram: write with an empty byte mask at %h", addr);

endmodule

// ==== load_align.sv ====
`timescale 1ns/1ps

module load_align (
  input  lsu_pkg::xlen_t      read_dword,
  input  mem_pkg::lane_mask_t byte_mask,
  input  logic [2:0]          offset,
  input  lsu_pkg::acc_size_e  size,
  input  logic                load_unsigned,
  input  logic                ld_en,
  output lsu_pkg::xlen_t      rdata
);

  import lsu_pkg::*;
  import mem_pkg::*;

  dword_u raw;
  dword_u masked;
  xlen_t  extended;

  assign raw.d = read_dword;

  // drop lanes the access does not own
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      masked.b[i] = byte_mask[i] ? raw.b[i] : 8'h00;
    end
  end

  // pick the slot named by the offset in the view of the access size
  // then sign or zero extend
  always_comb begin
    case (size)
      sz_byte: begin
        extended = {{56{masked.b[offset][7] & ~load_unsigned}},
                    masked.b[offset]};
      end
      sz_half: begin
        extended = {{48{masked.h[offset[2:1]][15] & ~load_unsigned}},
                    masked.h[offset[2:1]]};
      end
      sz_word: begin
        extended = {{32{masked.w[offset[2]][31] & ~load_unsigned}},
                    masked.w[offset[2]]};
      end
      default: extended = masked.d;
    endcase
  end

  assign rdata = ld_en ? extended : '0;

  // an enabled load always owns the lane its offset names
  always_comb begin
    assert final (!ld_en || byte_mask[offset])
      else $error("load_align: load at offset %0d without its lane", offset);
  end

endmodule

// ==== lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data path width in bits
`define LSU_XLEN 64

// number of dwords in the data ram, as log2
`define LSU_RAM_WORDS_LOG2 10

// byte address where the ram window starts
`define LSU_RAM_BASE 64'h8000_0000

`endif

// ==== lsu_pkg.sv ====
package lsu_pkg;

  // access size as encoded by the core
  // funct3[1:0] of the load/store instruction
  typedef enum logic [1:0] {
    sz_byte  = 2'b00,
    sz_half  = 2'b01,
    sz_word  = 2'b10,
    sz_dword = 2'b11
  } acc_size_e;

  // address, store data and load result
  typedef logic [63:0] xlen_t;

endpackage

// ==== lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ena,
  input  logic               wen,
  input  lsu_pkg::acc_size_e size,
  input  logic               load_unsigned,
  input  lsu_pkg::xlen_t     addr,
  input  lsu_pkg::xlen_t     wdata,
  output lsu_pkg::xlen_t     rdata,
  output logic               misaligned,
  output logic               access_fault
);

  import lsu_pkg::*;
  import mem_pkg::*;

  lane_mask_t byte_mask;
  xlen_t      store_dword;
  xlen_t      read_dword;
  logic       lane_misaligned;
  logic       ld_en;

  store_lane_unit i_store_lane_unit (
    .addr        (addr),
    .size        (size),
    .wdata       (wdata),
    .byte_mask   (byte_mask),
    .store_dword (store_dword),
    .misaligned  (lane_misaligned)
  );

  data_ram i_data_ram (
    .clk          (clk),
    .rst_n        (rst_n),
    .ena          (ena),
    .wen          (wen),
    .addr         (addr),
    .byte_mask    (byte_mask),
    .store_dword  (store_dword),
    .misaligned   (lane_misaligned),
    .read_dword   (read_dword),
    .access_fault (access_fault)
  );

  // flag only reported for a real access
  assign misaligned = ena & lane_misaligned;

  // a clean enabled load
  assign ld_en = ena & ~wen & ~lane_misaligned & ~access_fault;

  load_align i_load_align (
    .read_dword    (read_dword),
    .byte_mask     (byte_mask),
    .offset        (addr[2:0]),
    .size          (size),
    .load_unsigned (load_unsigned),
    .ld_en         (ld_en),
    .rdata         (rdata)
  );

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

  // one enable bit per byte lane, lane 0 is the lowest byte
  typedef logic [7:0] lane_mask_t;

  // one dword seen as bytes, halfwords, words or a whole,
  // element 0 is always the least significant one
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    logic [63:0]      d;
  } dword_u;

endpackage

// ==== store_lane_unit.sv ====
`timescale 1ns/1ps

module store_lane_unit (
  input  lsu_pkg::xlen_t     addr,
  input  lsu_pkg::acc_size_e size,
  input  lsu_pkg::xlen_t     wdata,
  output mem_pkg::lane_mask_t byte_mask,
  output lsu_pkg::xlen_t     store_dword,
  output logic               misaligned
);

  import lsu_pkg::*;
  import mem_pkg::*;

  logic [2:0] offset;
  logic       aligned;
  lane_mask_t base_mask;
  dword_u     src;
  dword_u     rep;
  logic [7:0] run_end;

  assign offset = addr[2:0];
  assign src.d  = wdata;

  // lanes covered by the access before shifting to the offset
  always_comb begin
    case (size)
      sz_byte: begin
        aligned   = 1'b1;
        base_mask = 8'h01;
      end
      sz_half: begin
        aligned   = ~offset[0];
        base_mask = 8'h03;
      end
      sz_word: begin
        aligned   = (offset[1:0] == 2'b00);
        base_mask = 8'h0f;
      end
      default: begin
        aligned   = (offset == 3'b000);
        base_mask = 8'hff;
      end
    endcase
  end

  assign byte_mask  = aligned ? lane_mask_t'(base_mask << offset) : '0;
  assign misaligned = ~aligned;

  // copy the low part of wdata into every slot of the access width
  // so the ram just picks lanes by mask
  always_comb begin
    rep.d = '0;
    case (size)
      sz_byte: begin
        for (int i = 0; i < 8; i++) begin
          rep.b[i] = src.b[0];
        end
      end
      sz_half: begin
        for (int i = 0; i < 4; i++) begin
          rep.h[i] = src.h[0];
        end
      end
      sz_word: begin
        for (int i = 0; i < 2; i++) begin
          rep.w[i] = src.w[0];
        end
      end
      default: rep.d = src.d;
    endcase
  end

  assign store_dword = rep.d;

  // adding the lowest set bit clears a contiguous run completely
  assign run_end = byte_mask + (byte_mask & (~byte_mask + 8'd1));

  // legal masks are empty or one contiguous run of 1, 2, 4 or 8 lanes
  always_comb begin
    assert final ((byte_mask == '0) ||
                  (((run_end & byte_mask) == '0) &&
                   ($countones(byte_mask) inside {1, 2, 4, 8})))
      else $error("store_lane_unit: illegal byte mask %b", byte_mask);
  end

endmodule

// ==== tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu;

  import lsu_pkg::*;

  localparam int    reset_cycles = 5;
  localparam int    slack_cycles = 20;
  localparam xlen_t ram_base     = `LSU_RAM_BASE;
  localparam xlen_t ram_bytes    = xlen_t'(1) << (`LSU_RAM_WORDS_LOG2 + 3);
  // last dword inside the window and the first dwords just outside it
  localparam xlen_t last_dword   = ram_base + ram_bytes - 64'd8;
  localparam xlen_t past_window  = ram_base + ram_bytes;
  localparam xlen_t below_window = ram_base - 64'd8;

  typedef struct {
    logic      ena;
    logic      wen;
    acc_size_e size;
    logic      load_unsigned;
    xlen_t     addr;
    xlen_t     wdata;
    xlen_t     exp_rdata;
    logic      exp_misaligned;
    logic      exp_fault;
  } row_t;

  logic      clk;
  logic      rst_n;
  logic      ena;
  logic      wen;
  acc_size_e size;
  logic      load_unsigned;
  xlen_t     addr;
  xlen_t     wdata;
  xlen_t     rdata;
  logic      misaligned;
  logic      access_fault;

  row_t stim_q[$];
  int   cycle_limit;
  int   cycles = 0;

  lsu_top i_lsu_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .ena           (ena),
    .wen           (wen),
    .size          (size),
    .load_unsigned (load_unsigned),
    .addr          (addr),
    .wdata         (wdata),
    .rdata         (rdata),
    .misaligned    (misaligned),
    .access_fault  (access_fault)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic append_row(input logic e, input logic w, input acc_size_e sz,
                            input logic uns, input xlen_t a, input xlen_t wd,
                            input xlen_t exp_rd, input logic exp_mis,
                            input logic exp_flt);
    row_t r;
    r.ena            = e;
    r.wen            = w;
    r.size           = sz;
    r.load_unsigned  = uns;
    r.addr           = a;
    r.wdata          = wd;
    r.exp_rdata      = exp_rd;
    r.exp_misaligned = exp_mis;
    r.exp_fault      = exp_flt;
    stim_q.push_back(r);
  endtask

  // stores never return data
  task automatic store_row(input acc_size_e sz, input xlen_t a, input xlen_t wd,
                           input logic exp_mis, input logic exp_flt);
    append_row(1'b1, 1'b1, sz, 1'b0, a, wd, '0, exp_mis, exp_flt);
  endtask

  task automatic load_row(input acc_size_e sz, input logic uns, input xlen_t a,
                          input xlen_t exp_rd, input logic exp_mis,
                          input logic exp_flt);
    append_row(1'b1, 1'b0, sz, uns, a, 64'h0, exp_rd, exp_mis, exp_flt);
  endtask

  // ena low with the other inputs driven arbitrarily
  task automatic idle_row(input logic w, input xlen_t a, input xlen_t wd);
    append_row(1'b0, w, sz_dword, 1'b0, a, wd, '0, 1'b0, 1'b0);
  endtask

  task automatic build_table();
    // dword round trip and idle cycles
    store_row(sz_dword, ram_base, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, ram_base, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
    idle_row(1'b0, ram_base, 64'h0);
    idle_row(1'b1, ram_base, 64'hffff_ffff_ffff_ffff);
    load_row(sz_dword, 1'b0, ram_base, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0);

    // partial stores merge into the dword at base + 8
    store_row(sz_dword, ram_base + 64'd8, 64'h0, 1'b0, 1'b0);
    store_row(sz_byte, ram_base + 64'd8, 64'hffff_ffff_ffff_ff11, 1'b0, 1'b0);
    store_row(sz_byte, ram_base + 64'd13, 64'hffff_ffff_ffff_ff22, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, ram_base + 64'd8, 64'h0000_2200_0000_0011, 1'b0, 1'b0);
    store_row(sz_half, ram_base + 64'd10, 64'hffff_ffff_ffff_3344, 1'b0, 1'b0);
    store_row(sz_half, ram_base + 64'd14, 64'hffff_ffff_ffff_5566, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, ram_base + 64'd8, 64'h5566_2200_3344_0011, 1'b0, 1'b0);
    store_row(sz_word, ram_base + 64'd12, 64'hffff_ffff_7788_99aa, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, ram_base + 64'd8, 64'h7788_99aa_3344_0011, 1'b0, 1'b0);
    store_row(sz_word, ram_base + 64'd8, 64'h0000_0000_bbcc_ddee, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, ram_base + 64'd8, 64'h7788_99aa_bbcc_ddee, 1'b0, 1'b0);
    // top byte 0x77 is positive so no sign fill
    load_row(sz_byte, 1'b0, ram_base + 64'd15, 64'h0000_0000_0000_0077, 1'b0, 1'b0);

    // remaining half and byte offsets merge into the dword at base + 24
    store_row(sz_dword, ram_base + 64'd24, 64'h0, 1'b0, 1'b0);
    store_row(sz_half, ram_base + 64'd24, 64'hffff_ffff_ffff_1122, 1'b0, 1'b0);
    store_row(sz_half, ram_base + 64'd28, 64'hffff_ffff_ffff_3344, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, ram_base + 64'd24, 64'h0000_3344_0000_1122, 1'b0, 1'b0);
    store_row(sz_byte, ram_base + 64'd25, 64'hffff_ffff_ffff_ff55, 1'b0, 1'b0);
    store_row(sz_byte, ram_base + 64'd26, 64'hffff_ffff_ffff_ff66, 1'b0, 1'b0);
    store_row(sz_byte, ram_base + 64'd27, 64'hffff_ffff_ffff_ff77, 1'b0, 1'b0);
    store_row(sz_byte, ram_base + 64'd28, 64'hffff_ffff_ffff_ff88, 1'b0, 1'b0);
    store_row(sz_byte, ram_base + 64'd30, 64'hffff_ffff_ffff_ff99, 1'b0, 1'b0);
    store_row(sz_byte, ram_base + 64'd31, 64'hffff_ffff_ffff_ffaa, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, ram_base + 64'd24, 64'haa99_3388_7766_5522, 1'b0, 1'b0);

    // sign and zero extension from base + 16
    store_row(sz_dword, ram_base + 64'd16, 64'h89ab_cdef_f0e1_d2c3, 1'b0, 1'b0);
    load_row(sz_byte, 1'b0, ram_base + 64'd16, 64'hffff_ffff_ffff_ffc3, 1'b0, 1'b0);
    load_row(sz_byte, 1'b1, ram_base + 64'd16, 64'h0000_0000_0000_00c3, 1'b0, 1'b0);
    load_row(sz_byte, 1'b0, ram_base + 64'd23, 64'hffff_ffff_ffff_ff89, 1'b0, 1'b0);
    load_row(sz_byte, 1'b1, ram_base + 64'd21, 64'h0000_0000_0000_00cd, 1'b0, 1'b0);
    load_row(sz_half, 1'b0, ram_base + 64'd18, 64'hffff_ffff_ffff_f0e1, 1'b0, 1'b0);
    load_row(sz_half, 1'b1, ram_base + 64'd22, 64'h0000_0000_0000_89ab, 1'b0, 1'b0);
    load_row(sz_word, 1'b0, ram_base + 64'd16, 64'hffff_ffff_f0e1_d2c3, 1'b0, 1'b0);
    load_row(sz_word, 1'b1, ram_base + 64'd20, 64'h0000_0000_89ab_cdef, 1'b0, 1'b0);
    load_row(sz_word, 1'b0, ram_base + 64'd20, 64'hffff_ffff_89ab_cdef, 1'b0, 1'b0);

    // misaligned accesses flag and leave memory untouched
    load_row(sz_half, 1'b0, ram_base + 64'd17, 64'h0, 1'b1, 1'b0);
    load_row(sz_dword, 1'b0, ram_base + 64'd3, 64'h0, 1'b1, 1'b0);
    store_row(sz_word, ram_base + 64'd18, 64'h0, 1'b1, 1'b0);
    store_row(sz_dword, ram_base + 64'd20, 64'h0, 1'b1, 1'b0);
    load_row(sz_dword, 1'b0, ram_base + 64'd16, 64'h89ab_cdef_f0e1_d2c3, 1'b0, 1'b0);
    idle_row(1'b0, ram_base + 64'd1, 64'h0);

    // out-of-window accesses fault, read zero and do not alias
    store_row(sz_dword, last_dword, 64'h5a5a_0000_ffff_a5a5, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, last_dword, 64'h5a5a_0000_ffff_a5a5, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, below_window, 64'h0, 1'b0, 1'b1);
    store_row(sz_dword, below_window, 64'hdead_dead_dead_dead, 1'b0, 1'b1);
    load_row(sz_dword, 1'b0, last_dword, 64'h5a5a_0000_ffff_a5a5, 1'b0, 1'b0);
    load_row(sz_dword, 1'b0, past_window, 64'h0, 1'b0, 1'b1);
    store_row(sz_dword, past_window, 64'hbeef_beef_beef_beef, 1'b0, 1'b1);
    load_row(sz_dword, 1'b0, ram_base, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
    load_row(sz_byte, 1'b1, 64'hffff_ffff_ffff_fff0, 64'h0, 1'b0, 1'b1);
    // both flags at once
    load_row(sz_half, 1'b0, ram_base - 64'd1, 64'h0, 1'b1, 1'b1);
    idle_row(1'b0, past_window, 64'h0);
  endtask

  task automatic check_data(input string name, input xlen_t expected,
                            input xlen_t actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %h, got %h",
               $time, name, expected, actual);
      $display("Verification failed");
      $fatal(1, "data mismatch on %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic expected,
                            input logic actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %b, got %b",
               $time, name, expected, actual);
      $display("Verification failed");
      $fatal(1, "flag mismatch on %s", name);
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    ena           = 1'b0;
    wen           = 1'b0;
    size          = sz_byte;
    load_unsigned = 1'b0;
    addr          = '0;
    wdata         = '0;

    build_table();
    cycle_limit = stim_q.size() + reset_cycles + slack_cycles;

    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    // quiet outputs right after reset
    @(negedge clk);
    check_data("rdata after reset", '0, rdata);
    check_flag("misaligned after reset", 1'b0, misaligned);
    check_flag("access_fault after reset", 1'b0, access_fault);

    foreach (stim_q[i]) begin
      @(posedge clk);
      ena           <= stim_q[i].ena;
      wen           <= stim_q[i].wen;
      size          <= stim_q[i].size;
      load_unsigned <= stim_q[i].load_unsigned;
      addr          <= stim_q[i].addr;
      wdata         <= stim_q[i].wdata;
      // outputs settle well before the next edge
      @(negedge clk);
      check_data($sformatf("rdata row %0d", i), stim_q[i].exp_rdata, rdata);
      check_flag($sformatf("misaligned row %0d", i),
                 stim_q[i].exp_misaligned, misaligned);
      check_flag($sformatf("access_fault row %0d", i),
                 stim_q[i].exp_fault, access_fault);
    end

    $display("Verification passed");
    $finish;
  end

  // watchdog for a hung run
  initial begin
    @(posedge clk);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not end within %0d clock cycles", cycle_limit);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

endmodule
